/* design/laser_pkg.sv */
package laser_pkg;

    // Timing on the single clock
    localparam int bit_period  = 8;
    localparam int data_bits   = 8;
    localparam int frame_bits  = 10;
    localparam int queue_depth = 4;
    localparam int sync_stages = 2;

    localparam int bit_cnt_w   = $clog2(bit_period);
    localparam int frame_cnt_w = $clog2(frame_bits);
    localparam int queue_ptr_w = $clog2(queue_depth);

    // Three vote samples in the middle of each bit
    localparam logic [bit_cnt_w-1:0] vote_first = bit_cnt_w'(3);
    localparam logic [bit_cnt_w-1:0] vote_last  = bit_cnt_w'(5);
    localparam logic [bit_cnt_w-1:0] bit_last   = bit_cnt_w'(bit_period - 1);

    // Bit index 0 is the start bit
    localparam logic [frame_cnt_w-1:0] frame_last = frame_cnt_w'(frame_bits - 1);
    localparam logic [frame_cnt_w-1:0] rx_last    = frame_cnt_w'(data_bits);

    localparam logic [queue_ptr_w:0] queue_full = (queue_ptr_w + 1)'(queue_depth);

    // FIFO chip write phases
    localparam logic [1:0] wr_idle  = 2'd0;
    localparam logic [1:0] wr_setup = 2'd1;
    localparam logic [1:0] wr_low1  = 2'd2;
    localparam logic [1:0] wr_low2  = 2'd3;

    typedef union packed {
        logic [2*data_bits-1:0] raw;
        struct packed {
            logic [data_bits-1:0] lane2;
            logic [data_bits-1:0] lane1;
        } bytes;
    } lane_pair_u;

endpackage

/* design/lane_pair_if.sv */
`timescale 1ns/1ps

interface lane_pair_if;

    logic [7:0] lane1;
    logic [7:0] lane2;
    // One-cycle offer, only while busy is low
    logic       valid;
    logic       busy;

    modport reader (
        output lane1,
        output lane2,
        output valid,
        input  busy
    );

    modport transmitter (
        input  lane1,
        input  lane2,
        input  valid,
        output busy
    );

endinterface

/* design/ftdi_reader.sv */
`timescale 1ns/1ps

module ftdi_reader (
    input  logic        clock,
    input  logic        reset,
    input  logic        rxf,
    input  logic [7:0]  adbus_in,
    output logic        ftdi_rd,
    lane_pair_if.reader pair
);

    // High during the single read strobe cycle
    logic strobe;
    // Next captured byte belongs to lane 2
    logic second;
    // Full pair waiting for the transmitter
    logic pending;

    assign ftdi_rd = ~strobe;

    // Offer the pair as soon as the transmitter is idle
    assign pair.valid = pending & ~pair.busy;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            strobe  <= 1'b0;
            second  <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (strobe) begin
                // Byte taken, always one idle cycle after the strobe
                strobe <= 1'b0;
                second <= ~second;
                if (second) begin
                    pending <= 1'b1;
                end
            end else if (~rxf && ~pending) begin
                strobe <= 1'b1;
            end

            if (pair.valid) begin
                pending <= 1'b0;
            end
        end
    end

    // Capture at the end of the strobe cycle
    always_ff @(posedge clock) begin
        if (strobe) begin
            if (second) begin
                pair.lane2 <= adbus_in;
            end else begin
                pair.lane1 <= adbus_in;
            end
        end
    end

endmodule

/* design/laser_transmitter.sv */
`timescale 1ns/1ps

module laser_transmitter (
    input  logic             clock,
    input  logic             reset,
    lane_pair_if.transmitter pair,
    output logic             laser1_tx,
    output logic             laser2_tx
);

    logic [laser_pkg::data_bits-1:0]   data1_q;
    logic [laser_pkg::data_bits-1:0]   data2_q;
    logic [laser_pkg::frame_bits-1:0]  frame1;
    logic [laser_pkg::frame_bits-1:0]  frame2;
    logic                              active;
    logic [laser_pkg::bit_cnt_w-1:0]   cyc;
    logic [laser_pkg::frame_cnt_w-1:0] bit_idx;

    // Stop low, data LSB first, start high at index 0
    assign frame1 = {1'b0, data1_q, 1'b1};
    assign frame2 = {1'b0, data2_q, 1'b1};

    assign pair.busy = active;

    // Both lanes share one bit position
    assign laser1_tx = active & frame1[bit_idx];
    assign laser2_tx = active & frame2[bit_idx];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active  <= 1'b0;
            cyc     <= '0;
            bit_idx <= '0;
        end else if (!active) begin
            if (pair.valid) begin
                active  <= 1'b1;
                cyc     <= '0;
                bit_idx <= '0;
            end
        end else begin
            cyc <= cyc + 1'b1;
            if (cyc == laser_pkg::bit_last) begin
                // Last cycle of the stop bit ends the frame
                if (bit_idx == laser_pkg::frame_last) begin
                    active <= 1'b0;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pair.valid && !active) begin
            data1_q <= pair.lane1;
            data2_q <= pair.lane2;
        end
    end

endmodule

/* design/laser_receiver.sv */
`timescale 1ns/1ps

module laser_receiver (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  laser1_rx,
    input  logic                  laser2_rx,
    output logic                  rx_valid,
    output laser_pkg::lane_pair_u rx_pair
);

    logic [laser_pkg::sync_stages-1:0] sync1;
    logic [laser_pkg::sync_stages-1:0] sync2;
    logic                              prev1;
    logic                              prev2;
    logic                              lane1;
    logic                              lane2;
    logic                              rise;
    logic                              active;
    logic [laser_pkg::bit_cnt_w-1:0]   cyc;
    logic [laser_pkg::frame_cnt_w-1:0] bit_idx;
    logic [1:0]                        votes1;
    logic [1:0]                        votes2;
    logic                              in_window;
    logic                              bit_end;
    logic                              bit1;
    logic                              bit2;
    laser_pkg::lane_pair_u             shift_q;

    assign lane1 = sync1[laser_pkg::sync_stages-1];
    assign lane2 = sync2[laser_pkg::sync_stages-1];

    // Either lane can start a frame
    assign rise = (lane1 & ~prev1) | (lane2 & ~prev2);

    assign in_window = (cyc >= laser_pkg::vote_first) && (cyc <= laser_pkg::vote_last);
    assign bit_end   = cyc == laser_pkg::bit_last;

    // Two or three high samples out of three
    assign bit1 = votes1[1];
    assign bit2 = votes2[1];

    assign rx_pair = shift_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync1 <= '0;
            sync2 <= '0;
            prev1 <= 1'b0;
            prev2 <= 1'b0;
        end else begin
            sync1 <= {sync1[laser_pkg::sync_stages-2:0], laser1_rx};
            sync2 <= {sync2[laser_pkg::sync_stages-2:0], laser2_rx};
            prev1 <= lane1;
            prev2 <= lane2;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            cyc      <= '0;
            bit_idx  <= '0;
            votes1   <= '0;
            votes2   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!active) begin
                if (rise) begin
                    active  <= 1'b1;
                    cyc     <= '0;
                    bit_idx <= '0;
                    votes1  <= '0;
                    votes2  <= '0;
                end
            end else begin
                cyc <= cyc + 1'b1;
                if (in_window) begin
                    votes1 <= votes1 + {1'b0, lane1};
                    votes2 <= votes2 + {1'b0, lane2};
                end
                if (bit_end) begin
                    votes1 <= '0;
                    votes2 <= '0;
                    if (bit_idx == '0 && !bit1 && !bit2) begin
                        // Start bit did not hold, treat as a glitch
                        active <= 1'b0;
                    end else if (bit_idx == laser_pkg::rx_last) begin
                        active   <= 1'b0;
                        rx_valid <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
            end
        end
    end

    // Data bits arrive LSB first, shift in from the top
    always_ff @(posedge clock) begin
        if (active && bit_end && bit_idx != '0) begin
            shift_q.bytes.lane1 <= {bit1, shift_q.bytes.lane1[laser_pkg::data_bits-1:1]};
            shift_q.bytes.lane2 <= {bit2, shift_q.bytes.lane2[laser_pkg::data_bits-1:1]};
        end
    end

endmodule

/* design/rx_queue.sv */
`timescale 1ns/1ps

module rx_queue (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push,
    input  laser_pkg::lane_pair_u push_pair,
    input  logic                  pop,
    output laser_pkg::lane_pair_u pop_pair,
    output logic                  empty
);

    logic [$bits(laser_pkg::lane_pair_u)-1:0] mem [laser_pkg::queue_depth];
    logic [laser_pkg::queue_ptr_w-1:0]        wr_ptr;
    logic [laser_pkg::queue_ptr_w-1:0]        rd_ptr;
    logic [laser_pkg::queue_ptr_w:0]          count;
    logic                                     full;
    logic                                     do_push;
    logic                                     do_pop;

    assign full  = count == laser_pkg::queue_full;
    assign empty = count == '0;

    // Pairs arriving while full are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign pop_pair.raw = mem[rd_ptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pair.raw;
        end
    end

endmodule

/* design/ftdi_writer.sv */
`timescale 1ns/1ps

module ftdi_writer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  txe,
    input  logic                  empty,
    input  laser_pkg::lane_pair_u pop_pair,
    output logic                  pop,
    output logic                  ftdi_wr,
    output logic                  adbus_oe,
    output logic [7:0]            adbus_out
);

    logic [1:0] phase;
    // Lane 2 byte of the current pair
    logic       upper;

    // Bus driven from setup through both strobe cycles
    assign adbus_oe = phase != laser_pkg::wr_idle;
    assign ftdi_wr  = ~(phase == laser_pkg::wr_low1 || phase == laser_pkg::wr_low2);

    assign adbus_out = upper ? pop_pair.bytes.lane2 : pop_pair.bytes.lane1;

    // Entry leaves the queue only once both bytes are out
    assign pop = (phase == laser_pkg::wr_low2) && upper;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= laser_pkg::wr_idle;
            upper <= 1'b0;
        end else begin
            case (phase)
                laser_pkg::wr_idle: begin
                    // Each byte waits for room in the chip
                    if (~txe && ~empty) begin
                        phase <= laser_pkg::wr_setup;
                    end
                end
                laser_pkg::wr_setup: begin
                    phase <= laser_pkg::wr_low1;
                end
                laser_pkg::wr_low1: begin
                    phase <= laser_pkg::wr_low2;
                end
                default: begin
                    phase <= laser_pkg::wr_idle;
                    upper <= ~upper;
                end
            endcase
        end
    end

endmodule

/* design/laser_bridge.sv */
`timescale 1ns/1ps

module laser_bridge (
    input  logic       clock,
    input  logic       reset,
    input  logic       rxf,
    input  logic       txe,
    input  logic [7:0] adbus_in,
    input  logic       laser1_rx,
    input  logic       laser2_rx,
    output logic       ftdi_rd,
    output logic       ftdi_wr,
    output logic       adbus_oe,
    output logic [7:0] adbus_out,
    output logic       laser1_tx,
    output logic       laser2_tx
);

    logic                  rx_valid;
    laser_pkg::lane_pair_u rx_pair;
    logic                  pop;
    laser_pkg::lane_pair_u pop_pair;
    logic                  empty;

    lane_pair_if pair_bus ();

    // Input side
    ftdi_reader reader_inst (
        .clock    (clock),
        .reset    (reset),
        .rxf      (rxf),
        .adbus_in (adbus_in),
        .ftdi_rd  (ftdi_rd),
        .pair     (pair_bus.reader)
    );

    laser_transmitter transmitter_inst (
        .clock     (clock),
        .reset     (reset),
        .pair      (pair_bus.transmitter),
        .laser1_tx (laser1_tx),
        .laser2_tx (laser2_tx)
    );

    laser_receiver receiver_inst (
        .clock     (clock),
        .reset     (reset),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx),
        .rx_valid  (rx_valid),
        .rx_pair   (rx_pair)
    );

    // Output side
    rx_queue queue_inst (
        .clock     (clock),
        .reset     (reset),
        .push      (rx_valid),
        .push_pair (rx_pair),
        .pop       (pop),
        .pop_pair  (pop_pair),
        .empty     (empty)
    );

    ftdi_writer writer_inst (
        .clock     (clock),
        .reset     (reset),
        .txe       (txe),
        .empty     (empty),
        .pop_pair  (pop_pair),
        .pop       (pop),
        .ftdi_wr   (ftdi_wr),
        .adbus_oe  (adbus_oe),
        .adbus_out (adbus_out)
    );

endmodule

/* tests/laser_bridge_chk.sv */
`timescale 1ns/1ps

module laser_bridge_chk (
    input logic clock,
    input logic reset,
    input logic rxf,
    input logic ftdi_rd,
    input logic ftdi_wr,
    input logic adbus_oe
);

    // Failed assertions, read by the testbench at the end of the run
    int failures = 0;

    // Read strobe is a single cycle
    rd_single: assert property (@(posedge clock) disable iff (reset) !ftdi_rd |=> ftdi_rd)
        else begin
            failures++;
            $error("ftdi_rd stayed low for more than one cycle");
        end

    // Write strobe only with the bus driven
    wr_with_oe: assert property (@(posedge clock) disable iff (reset) !ftdi_wr |-> adbus_oe)
        else begin
            failures++;
            $error("ftdi_wr low while adbus_oe is low");
        end

    // A new read only when the chip has data
    rd_needs_data: assert property (@(posedge clock) disable iff (reset)
        $fell(ftdi_rd) |-> $past(!rxf))
        else begin
            failures++;
            $error("ftdi_rd fell although rxf was high");
        end

endmodule

bind laser_bridge laser_bridge_chk chk_inst (
    .clock    (clock),
    .reset    (reset),
    .rxf      (rxf),
    .ftdi_rd  (ftdi_rd),
    .ftdi_wr  (ftdi_wr),
    .adbus_oe (adbus_oe)
);

/* tests/laser_bridge_tb.sv */
`timescale 1ns/1ps

module laser_bridge_tb;

    localparam int frame_cycles = laser_pkg::frame_bits * laser_pkg::bit_period;
    localparam int wait_limit   = 1000;
    localparam int row_count    = 12;

    localparam logic [1:0] mode_loop   = 2'd0;
    localparam logic [1:0] mode_hold   = 2'd1;
    localparam logic [1:0] mode_glitch = 2'd2;
    localparam logic [1:0] mode_vote   = 2'd3;

    typedef struct packed {
        logic [1:0] mode;
        logic [7:0] lane1;
        logic [7:0] lane2;
        // Pair must show up on the write side
        logic       kept;
    } row_t;

    // Six held pairs into a four-entry queue lose the last two
    row_t rows [row_count] = '{
        {mode_loop,   8'h5a, 8'ha5, 1'b1},
        {mode_loop,   8'h01, 8'h80, 1'b1},
        {mode_loop,   8'hff, 8'h00, 1'b1},
        {mode_loop,   8'h3c, 8'hc3, 1'b1},
        {mode_hold,   8'h11, 8'h22, 1'b1},
        {mode_hold,   8'h33, 8'h44, 1'b1},
        {mode_hold,   8'h55, 8'h66, 1'b1},
        {mode_hold,   8'h77, 8'h88, 1'b1},
        {mode_hold,   8'h99, 8'haa, 1'b0},
        {mode_hold,   8'hbb, 8'hcc, 1'b0},
        {mode_glitch, 8'he7, 8'h18, 1'b1},
        {mode_vote,   8'h96, 8'h69, 1'b1}
    };

    logic        clock;
    logic        reset;
    logic        rxf = 1'b1;
    logic        txe;
    logic [7:0]  adbus_in = 8'h00;
    logic        laser1_rx;
    logic        laser2_rx;
    logic        ftdi_rd;
    logic        ftdi_wr;
    logic        adbus_oe;
    logic [7:0]  adbus_out;
    logic        laser1_tx;
    logic        laser2_tx;
    logic        loopback;
    logic        drive1;
    logic        drive2;
    logic        wr_prev = 1'b1;
    logic [7:0]  rd_bytes [$];
    logic [7:0]  wr_log [$];
    logic [7:0]  expected [$];
    logic [31:0] lcg_state = 32'haf73;
    int          errors = 0;
    int          checks = 0;
    int          checked = 0;

    assign laser1_rx = loopback ? laser1_tx : drive1;
    assign laser2_rx = loopback ? laser2_tx : drive2;

    laser_bridge laser_bridge_inst (
        .clock     (clock),
        .reset     (reset),
        .rxf       (rxf),
        .txe       (txe),
        .adbus_in  (adbus_in),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx),
        .ftdi_rd   (ftdi_rd),
        .ftdi_wr   (ftdi_wr),
        .adbus_oe  (adbus_oe),
        .adbus_out (adbus_out),
        .laser1_tx (laser1_tx),
        .laser2_tx (laser2_tx)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        repeat (row_count * 400) @(posedge clock);
        $display("Run stopped by the watchdog, the tests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    // Read side of the FIFO chip gives one byte per read strobe
    always @(posedge clock) begin
        if (!reset && !ftdi_rd && rd_bytes.size() > 0) begin
            void'(rd_bytes.pop_front());
        end
        if (rd_bytes.size() > 0) begin
            rxf      <= 1'b0;
            adbus_in <= rd_bytes[0];
        end else begin
            rxf <= 1'b1;
        end
    end

    // Write side takes the byte on the first low cycle of ftdi_wr
    always @(posedge clock) begin
        if (!reset && !ftdi_wr && wr_prev) begin
            wr_log.push_back(adbus_out);
        end
        wr_prev <= ftdi_wr;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Line level in bit idx with start high, data LSB first and stop low
    function automatic logic frame_bit(input logic [7:0] data, input int idx);
        if (idx == 0) begin
            return 1'b1;
        end
        if (idx > laser_pkg::data_bits) begin
            return 1'b0;
        end
        return data[idx - 1];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_value,
                               input logic [31:0] act_value);
        checks++;
        if (exp_value !== act_value) begin
            errors++;
            $display("error at %0t: %s expected %0h, actual %0h",
                     $time, name, exp_value, act_value);
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    // Bytes join the read side between clock edges
    task automatic send_pair(input logic [7:0] b1, input logic [7:0] b2);
        @(negedge clock);
        rd_bytes.push_back(b1);
        rd_bytes.push_back(b2);
    endtask

    task automatic check_frame(input logic [7:0] b1, input logic [7:0] b2);
        int spent;
        spent = 0;
        @(negedge clock);
        while (!laser1_tx && spent < wait_limit) begin
            @(negedge clock);
            spent++;
        end
        if (!laser1_tx) begin
            errors++;
            $display("No start bit appeared on laser1_tx");
        end else begin
            for (int c = 0; c < frame_cycles; c++) begin
                check_value("laser1_tx", 32'(frame_bit(b1, c / laser_pkg::bit_period)),
                            32'(laser1_tx));
                check_value("laser2_tx", 32'(frame_bit(b2, c / laser_pkg::bit_period)),
                            32'(laser2_tx));
                @(negedge clock);
            end
        end
    endtask

    // Both transmitter lanes low for longer than any gap inside a frame
    task automatic wait_lasers_quiet(input int quiet_cycles);
        int quiet;
        int spent;
        quiet = 0;
        spent = 0;
        while ((rd_bytes.size() > 0 || quiet < quiet_cycles) && spent < wait_limit) begin
            @(negedge clock);
            spent++;
            if (laser1_tx || laser2_tx) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < quiet_cycles) begin
            errors++;
            $display("Transmitter never went idle after the held pairs");
        end
    endtask

    task automatic wait_writes(input int count);
        int spent;
        spent = 0;
        while (wr_log.size() < count && spent < wait_limit) begin
            @(negedge clock);
            spent++;
        end
        if (wr_log.size() < count) begin
            errors++;
            $display("Write side received %0d bytes, %0d were due", wr_log.size(), count);
        end
        while (checked < expected.size()) begin
            if (checked < wr_log.size()) begin
                check_value("adbus_out", 32'(expected[checked]), 32'(wr_log[checked]));
            end
            checked++;
        end
    endtask

    task automatic drive_glitch(input int len);
        for (int c = 0; c < len; c++) begin
            @(posedge clock);
            drive1 <= 1'b1;
            drive2 <= 1'b1;
        end
        @(posedge clock);
        drive1 <= 1'b0;
        drive2 <= 1'b0;
    endtask

    task automatic drive_frame(input logic [7:0] b1, input logic [7:0] b2, input logic flip);
        logic val1;
        logic val2;
        int   pos1;
        int   pos2;
        for (int idx = 0; idx < laser_pkg::frame_bits; idx++) begin
            val1 = frame_bit(b1, idx);
            val2 = frame_bit(b2, idx);
            pos1 = -1;
            pos2 = -1;
            // Receiver bit count trails the driven line by one cycle
            if (flip && idx < laser_pkg::frame_bits - 1) begin
                lcg_state = lcg_next(lcg_state);
                pos1 = int'(laser_pkg::vote_first) + 1 + int'(lcg_state[23:16]) % 3;
                lcg_state = lcg_next(lcg_state);
                pos2 = int'(laser_pkg::vote_first) + 1 + int'(lcg_state[23:16]) % 3;
            end
            for (int c = 0; c < laser_pkg::bit_period; c++) begin
                @(posedge clock);
                drive1 <= (c == pos1) ? ~val1 : val1;
                drive2 <= (c == pos2) ? ~val2 : val2;
            end
        end
    endtask

    initial begin
        logic next_hold;
        reset    = 1'b1;
        txe      = 1'b0;
        loopback = 1'b1;
        drive1   = 1'b0;
        drive2   = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("ftdi_rd", 32'(1), 32'(ftdi_rd));
        check_value("ftdi_wr", 32'(1), 32'(ftdi_wr));
        check_value("adbus_oe", 32'(0), 32'(adbus_oe));
        check_value("laser1_tx", 32'(0), 32'(laser1_tx));
        check_value("laser2_tx", 32'(0), 32'(laser2_tx));

        for (int r = 0; r < row_count; r++) begin
            next_hold = 1'b0;
            if (r + 1 < row_count) begin
                next_hold = rows[r + 1].mode == mode_hold;
            end
            case (rows[r].mode)
                mode_loop: begin
                    send_pair(rows[r].lane1, rows[r].lane2);
                    check_frame(rows[r].lane1, rows[r].lane2);
                end
                mode_hold: begin
                    @(posedge clock);
                    txe <= 1'b1;
                    send_pair(rows[r].lane1, rows[r].lane2);
                    if (!next_hold) begin
                        wait_lasers_quiet(frame_cycles + 2 * laser_pkg::bit_period);
                        @(posedge clock);
                        txe <= 1'b0;
                    end
                end
                mode_glitch: begin
                    @(posedge clock);
                    loopback <= 1'b0;
                    drive_glitch(2);
                    idle_cycles(frame_cycles);
                    check_value("write count", 32'(checked), 32'(wr_log.size()));
                    drive_frame(rows[r].lane1, rows[r].lane2, 1'b0);
                end
                default: begin
                    drive_frame(rows[r].lane1, rows[r].lane2, 1'b1);
                end
            endcase
            if (rows[r].kept) begin
                expected.push_back(rows[r].lane1);
                expected.push_back(rows[r].lane2);
            end
            if (rows[r].mode != mode_hold || !next_hold) begin
                wait_writes(expected.size());
            end
        end

        idle_cycles(2 * frame_cycles);
        check_value("write count", 32'(expected.size()), 32'(wr_log.size()));
        errors = errors + laser_bridge_inst.chk_inst.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, laser_bridge_inst.chk_inst.failures);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
design/laser_pkg.sv
design/lane_pair_if.sv
design/ftdi_reader.sv
design/laser_transmitter.sv
design/laser_receiver.sv
design/rx_queue.sv
design/ftdi_writer.sv
design/laser_bridge.sv
tests/laser_bridge_chk.sv
tests/laser_bridge_tb.sv

/* Makefile */
# Verilator build and run for the laser bridge testbench

VERILATOR ?= verilator
TOP       ?= laser_bridge_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard design/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
